// File: design/echo_ctrl.sv
`timescale 1ns/1ps

module echo_ctrl (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic                       rst_i,
   input  logic [soc_pkg::BYTE_W-1:0] rx_data_i,
   input  logic                       rx_valid_i,
   input  logic                       tx_busy_i,
   output logic [soc_pkg::BYTE_W-1:0] tx_data_o,
   output logic                       tx_start_o,
   output logic                       trap_o
);

   soc_pkg::ctrl_state_t state_q;
   logic                 is_trap;
   logic                 tx_free;

   assign is_trap = (rx_data_i == soc_pkg::TRAP_BYTE);

   // a strobe this cycle makes tx busy on the next one
   assign tx_free = !tx_busy_i && !tx_start_o;

   assign tx_start_o = (state_q == soc_pkg::CTRL_SEND) ||
                       (state_q == soc_pkg::CTRL_WAIT && !tx_busy_i);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= soc_pkg::CTRL_IDLE;
         trap_o  <= 1'b0;
      end else if (rst_i) begin
         state_q <= soc_pkg::CTRL_IDLE;
         trap_o  <= 1'b0;
      end else if (state_q != soc_pkg::CTRL_HALT) begin
         if (rx_valid_i && is_trap) begin
            state_q <= soc_pkg::CTRL_HALT;
            trap_o  <= 1'b1;
         end else if (rx_valid_i) begin
            // newest byte wins if one is still pending
            state_q <= tx_free ? soc_pkg::CTRL_SEND : soc_pkg::CTRL_WAIT;
         end else if (tx_start_o) begin
            state_q <= soc_pkg::CTRL_IDLE;
         end
      end
   end

   // one byte of storage, tx samples it with the start strobe
   always_ff @(posedge clk_i) begin
      if (rx_valid_i && !is_trap && state_q != soc_pkg::CTRL_HALT) begin
         tx_data_o <= rx_data_i;
      end
   end

endmodule

// File: design/reset_pulse_gen.sv
`timescale 1ns/1ps

module reset_pulse_gen #(
   parameter int START    = 5,
   parameter int DURATION = 10
) (
   input  logic clk_i,
   input  logic arst_n_i,
   input  logic start_i,
   output logic rst_o
);

   // wait phase and pulse phase run back to back on one counter
   localparam int CNT_W = $clog2(START + DURATION + 1);
   localparam logic [CNT_W-1:0] LAST = CNT_W'(START + DURATION - 1);

   logic [CNT_W-1:0] cnt_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q <= '0;
         rst_o <= 1'b1;
      end else if (start_i && rst_o) begin
         // rst stays high through both phases, drops after the last pulse cycle
         if (cnt_q == LAST) begin
            rst_o <= 1'b0;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

endmodule

// File: design/reset_sync.sv
`timescale 1ns/1ps

module reset_sync (
   input  logic clk_i,
   input  logic arst_n_i,
   output logic start_o
);

   logic [1:0] sync_q;

   // shift a one in once the external reset is released
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sync_q <= 2'b00;
      end else begin
         sync_q <= {sync_q[0], 1'b1};
      end
   end

   assign start_o = sync_q[1];

endmodule

// File: design/soc_pkg.sv
package soc_pkg;

   // width of one uart character
   localparam int BYTE_W = 8;

   // receiving this byte stops the echo and raises trap
   localparam logic [BYTE_W-1:0] TRAP_BYTE = 8'h1B;

   // echo controller states
   typedef enum logic [1:0] {
      CTRL_IDLE,
      // start strobe is on the wire this cycle
      CTRL_SEND,
      // byte held until the transmitter is free
      CTRL_WAIT,
      // trap seen, only arst_n_i gets us out
      CTRL_HALT
   } ctrl_state_t;

endpackage

// File: design/soc_wrapper.sv
`timescale 1ns/1ps

module soc_wrapper #(
   parameter int CLKS_PER_BIT = 16,
   parameter int START        = 5,
   parameter int DURATION     = 10
) (
   input  logic clk_i,
   input  logic arst_n_i,
   input  logic uart_rxd_i,
   output logic uart_txd_o,
   output logic trap_o
);

   logic                       start;
   logic                       rst;
   logic [soc_pkg::BYTE_W-1:0] rx_data;
   logic                       rx_valid;
   logic [soc_pkg::BYTE_W-1:0] tx_data;
   logic                       tx_start;
   logic                       tx_busy;

   reset_sync start_sync (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .start_o (start)
   );

   // board reset may never be pulsed, so make our own
   reset_pulse_gen #(
      .START   (START),
      .DURATION(DURATION)
   ) reset_pulse (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .start_i (start),
      .rst_o   (rst)
   );

   uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .rst_i(rst),
      .rxd_i(uart_rxd_i), .data_o(rx_data), .valid_o(rx_valid)
   );

   echo_ctrl ctrl (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .rst_i(rst),
      .rx_data_i(rx_data), .rx_valid_i(rx_valid), .tx_busy_i(tx_busy),
      .tx_data_o(tx_data), .tx_start_o(tx_start), .trap_o(trap_o)
   );

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .rst_i(rst),
      .data_i(tx_data), .start_i(tx_start), .txd_o(uart_txd_o), .busy_o(tx_busy)
   );

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic                       rst_i,
   input  logic                       rxd_i,
   output logic [soc_pkg::BYTE_W-1:0] data_o,
   output logic                       valid_o
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);
   localparam int IDX_W = $clog2(soc_pkg::BYTE_W + 2);
   localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2);
   localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [IDX_W-1:0] STOP_IDX = IDX_W'(soc_pkg::BYTE_W + 1);

   // [1] is the synchronized line, [2] its previous value
   logic [2:0]                 rxd_q;
   logic                       active;
   logic [CNT_W-1:0]           baud_cnt;
   logic [IDX_W-1:0]           bit_idx;
   logic [soc_pkg::BYTE_W-1:0] shift_q;
   logic                       sample;

   assign sample = active && (baud_cnt == '0);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rxd_q <= '1;
      end else begin
         rxd_q <= {rxd_q[1:0], rxd_i};
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         active   <= 1'b0;
         baud_cnt <= '0;
         bit_idx  <= '0;
         valid_o  <= 1'b0;
      end else if (rst_i) begin
         active   <= 1'b0;
         baud_cnt <= '0;
         bit_idx  <= '0;
         valid_o  <= 1'b0;
      end else begin
         valid_o <= 1'b0;
         if (!active) begin
            // falling edge starts a frame, first sample lands mid start bit
            if (rxd_q[2] && !rxd_q[1]) begin
               active   <= 1'b1;
               baud_cnt <= HALF_BIT;
               bit_idx  <= '0;
            end
         end else if (!sample) begin
            baud_cnt <= baud_cnt - 1'b1;
         end else begin
            baud_cnt <= FULL_BIT;
            if (bit_idx == '0 && rxd_q[1]) begin
               // glitch, start bit gone by mid-bit
               active <= 1'b0;
            end else if (bit_idx == STOP_IDX) begin
               active  <= 1'b0;
               valid_o <= rxd_q[1];
            end else begin
               bit_idx <= bit_idx + 1'b1;
            end
         end
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk_i) begin
      if (sample && bit_idx != '0 && bit_idx != STOP_IDX) begin
         shift_q <= {rxd_q[1], shift_q[soc_pkg::BYTE_W-1:1]};
      end
      if (sample && bit_idx == STOP_IDX) begin
         data_o <= shift_q;
      end
   end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic                       rst_i,
   input  logic [soc_pkg::BYTE_W-1:0] data_i,
   input  logic                       start_i,
   output logic                       txd_o,
   output logic                       busy_o
);

   localparam int FRAME_W = soc_pkg::BYTE_W + 2;
   localparam int CNT_W   = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [3:0]       LAST_BIT = 4'(FRAME_W - 1);

   // frame_q[0] is the bit on the line, ones shift in behind it
   logic [FRAME_W-1:0] frame_q;
   logic [CNT_W-1:0]   baud_cnt;
   logic [3:0]         bits_left;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         frame_q   <= '1;
         baud_cnt  <= '0;
         bits_left <= '0;
         busy_o    <= 1'b0;
      end else if (rst_i) begin
         frame_q   <= '1;
         baud_cnt  <= '0;
         bits_left <= '0;
         busy_o    <= 1'b0;
      end else if (!busy_o) begin
         // start strobes while busy are dropped here
         if (start_i) begin
            frame_q   <= {1'b1, data_i, 1'b0};
            baud_cnt  <= FULL_BIT;
            bits_left <= LAST_BIT;
            busy_o    <= 1'b1;
         end
      end else if (baud_cnt != '0) begin
         baud_cnt <= baud_cnt - 1'b1;
      end else begin
         frame_q  <= {1'b1, frame_q[FRAME_W-1:1]};
         baud_cnt <= FULL_BIT;
         if (bits_left == '0) begin
            // stop bit done
            busy_o <= 1'b0;
         end else begin
            bits_left <= bits_left - 1'b1;
         end
      end
   end

   assign txd_o = frame_q[0];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the soc_wrapper testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module soc_wrapper_tb \
   --Mdir obj_dir -o soc_wrapper_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/soc_wrapper_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed, see $LOG"
exit 1

// File: src.f
design/soc_pkg.sv
design/reset_sync.sv
design/reset_pulse_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/echo_ctrl.sv
design/soc_wrapper.sv
verif/soc_wrapper_properties.sv
verif/soc_wrapper_tb.sv

// File: verif/soc_wrapper_properties.sv
`timescale 1ns/1ps

module soc_wrapper_properties (
   input logic                 clk_i,
   input logic                 arst_n_i,
   input logic                 rst_i,
   input logic                 tx_start_i,
   input logic                 tx_busy_i,
   input logic                 trap_i,
   input soc_pkg::ctrl_state_t state_i
);

   // transmitter drops strobes while busy, so none may be issued then
   start_when_free: assert property (
      @(posedge clk_i) disable iff (!arst_n_i || rst_i)
      tx_start_i |-> !tx_busy_i
   ) else $error("tx_start_o pulsed while tx_busy_i was high");

   // only a reset takes trap down again
   trap_sticky: assert property (
      @(posedge clk_i) disable iff (!arst_n_i || rst_i)
      trap_i |=> trap_i
   ) else $error("trap_o fell without a reset");

   // trap output and halt state move together, no strobe once trapped
   no_start_halted: assert property (
      @(posedge clk_i) disable iff (!arst_n_i || rst_i)
      trap_i |-> (state_i == soc_pkg::CTRL_HALT) && !tx_start_i
   ) else $error("tx_start_o pulsed or halt state left while trap_o was high");

endmodule

bind echo_ctrl soc_wrapper_properties props (
   .clk_i     (clk_i),
   .arst_n_i  (arst_n_i),
   .rst_i     (rst_i),
   .tx_start_i(tx_start_o),
   .tx_busy_i (tx_busy_i),
   .trap_i    (trap_o),
   .state_i   (state_q)
);

// File: verif/soc_wrapper_tb.sv
`timescale 1ns/1ps

module soc_wrapper_tb;

   localparam int CLKS_PER_BIT = 8;
   localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
   localparam int NUM_RANDOM   = 20;

   logic                       clk;
   logic                       arst_n;
   logic                       uart_rxd;
   logic                       uart_txd;
   logic                       trap;
   integer                     seed;
   int                         rnd;
   int                         tests;
   int                         checks;
   int                         errors;
   int                         test_err_start;
   logic [soc_pkg::BYTE_W-1:0] sent [NUM_RANDOM];

   soc_wrapper #(.CLKS_PER_BIT(CLKS_PER_BIT)) uut (
      .clk_i(clk), .arst_n_i(arst_n), .uart_rxd_i(uart_rxd),
      .uart_txd_o(uart_txd), .trap_o(trap)
   );

   always #5 clk = ~clk;

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      assert (got == exp) else begin
         $display("Error at %0d ns: %s got %02h expected %02h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      assert (got === exp) else begin
         $display("Error at %0d ns: %s got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_cond(input bit ok, input string what);
      checks++;
      assert (ok) else begin
         $display("at %0d ns: %s", $time, what);
         errors++;
      end
   endtask

   // called on a falling edge, one bit per CLKS_PER_BIT cycles
   task automatic send_byte(input logic [7:0] data, input bit bad_stop);
      int bit_no;
      uart_rxd = 1'b0;
      repeat (CLKS_PER_BIT) @(negedge clk);
      for (bit_no = 0; bit_no < 8; bit_no++) begin
         uart_rxd = data[bit_no];
         repeat (CLKS_PER_BIT) @(negedge clk);
      end
      uart_rxd = !bad_stop;
      repeat (CLKS_PER_BIT) @(negedge clk);
      uart_rxd = 1'b1;
   endtask

   // returns after the middle of the stop bit
   task automatic recv_byte(input int limit, output logic [7:0] data, output bit timed_out);
      int waited;
      int bit_no;
      waited = 0;
      data = '0;
      while (uart_txd !== 1'b0 && waited < limit) begin
         @(negedge clk);
         waited++;
      end
      timed_out = (uart_txd !== 1'b0);
      if (!timed_out) begin
         repeat (CLKS_PER_BIT / 2) @(negedge clk);
         for (bit_no = 0; bit_no < 8; bit_no++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[bit_no] = uart_txd;
         end
         repeat (CLKS_PER_BIT) @(negedge clk);
      end
   endtask

   task automatic expect_echo(input logic [7:0] data);
      logic [7:0] got;
      bit         timed_out;
      fork
         send_byte(data, 1'b0);
         recv_byte(3 * FRAME_CYCLES, got, timed_out);
      join
      check_cond(!timed_out, $sformatf("no echo of %02h on uart_txd_o in time", data));
      if (!timed_out) begin
         check_byte("uart_txd_o", got, data);
      end
   endtask

   // nothing may come back within two frame times
   task automatic expect_silence(input logic [7:0] data, input bit bad_stop);
      logic [7:0] got;
      bit         timed_out;
      fork
         send_byte(data, bad_stop);
         recv_byte(2 * FRAME_CYCLES, got, timed_out);
      join
      check_cond(timed_out, $sformatf("unexpected frame %02h on uart_txd_o", got));
   endtask

   task automatic receive_sequence();
      logic [7:0] got;
      bit         timed_out;
      int         idx;
      for (idx = 0; idx < NUM_RANDOM; idx++) begin
         recv_byte(3 * FRAME_CYCLES, got, timed_out);
         check_cond(!timed_out, $sformatf("echo number %0d never arrived", idx));
         if (!timed_out) begin
            check_byte("uart_txd_o", got, sent[idx]);
         end
      end
   endtask

   task automatic send_sequence();
      int idx;
      for (idx = 0; idx < NUM_RANDOM; idx++) begin
         send_byte(sent[idx], 1'b0);
      end
   endtask

   // reset pulse plus the wait for the internal reset, idle line checked throughout
   task automatic apply_reset();
      arst_n = 1'b0;
      repeat (4) begin
         @(negedge clk);
         check_bit("uart_txd_o", uart_txd, 1'b1);
      end
      arst_n = 1'b1;
      repeat (20) begin
         @(negedge clk);
         check_bit("uart_txd_o", uart_txd, 1'b1);
         check_bit("trap_o", trap, 1'b0);
      end
   endtask

   task automatic start_test();
      test_err_start = errors;
      tests++;
   endtask

   task automatic end_test(input string name);
      $display("test %0d %s: %s", tests, name, (errors == test_err_start) ? "ok" : "FAILED");
   endtask

   initial begin
      clk = 1'b0;
      arst_n = 1'b0;
      uart_rxd = 1'b1;
      seed = 32'h4480_c0c7;
      tests = 0;
      checks = 0;
      errors = 0;
      test_err_start = 0;
      for (int i = 0; i < NUM_RANDOM; i++) begin
         do begin
            rnd = $random(seed);
         end while (rnd[7:0] == soc_pkg::TRAP_BYTE);
         sent[i] = rnd[7:0];
      end

      start_test();
      apply_reset();
      end_test("idle after reset");

      start_test();
      expect_echo(8'h5A);
      end_test("single echo");

      start_test();
      fork
         send_sequence();
         receive_sequence();
      join
      end_test("random back to back");

      start_test();
      expect_silence(8'h96, 1'b1);
      expect_echo(8'hA5);
      end_test("bad stop bit");

      start_test();
      expect_silence(soc_pkg::TRAP_BYTE, 1'b0);
      check_bit("trap_o", trap, 1'b1);
      expect_silence(8'h33, 1'b0);
      check_bit("trap_o", trap, 1'b1);
      end_test("trap halt");

      start_test();
      @(negedge clk);
      arst_n = 1'b0;
      repeat (4) @(negedge clk);
      check_bit("trap_o", trap, 1'b0);
      arst_n = 1'b1;
      repeat (20) @(negedge clk);
      expect_echo(8'hC3);
      end_test("reset clears trap");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
